// File: src/coh_pkg.sv
package coh_pkg;

  // Cache and bus geometry
  localparam int ADDR_BITS     = 32;
  localparam int LINE_BITS     = 256;
  localparam int WAYS          = 4;
  localparam int SETS          = 16;
  localparam int INDEX_BITS    = 4;
  localparam int NUM_CACHE     = 4;
  localparam int CACHE_ID_BITS = 2;
  localparam int WAY_BITS      = 2;

  typedef logic [WAYS-1:0] way_vec_t;

  // MESI line states plus the transients of a pending miss or snoop supply
  typedef enum logic [3:0] {
    CI,
    CS,
    CE,
    CM,
    // Waiting for own request, then for data
    CISAD,
    CISD,
    CIMAD,
    CIMD,
    // Upgrade from S
    CSMAD,
    CSMD,
    // Supplying data to another cache
    CSRD,
    CIRD
  } coh_state_e;

  typedef enum logic [1:0] {
    NONE,
    GETS,
    GETM
  } bus_op_e;

  typedef enum logic {
    DATA,
    EXCLUSIVE
  } resp_kind_e;

  // Request bus message
  typedef struct packed {
    logic                     valid;
    logic [CACHE_ID_BITS-1:0] source;
    logic [ADDR_BITS-1:0]     addr;
    bus_op_e                  op;
  } req_msg_t;

  // Response bus message, destination is a cache ID
  typedef struct packed {
    logic                     valid;
    logic [CACHE_ID_BITS-1:0] source;
    logic [WAY_BITS-1:0]      way;
    logic [CACHE_ID_BITS-1:0] destination;
    logic                     memory_flag;
    logic [ADDR_BITS-1:0]     addr;
    logic [LINE_BITS-1:0]     data;
    resp_kind_e               kind;
  } resp_msg_t;

  typedef struct packed {
    logic                 read;
    logic                 write;
    logic [ADDR_BITS-1:0] addr;
  } cpu_req_t;

  // Bus traffic as seen from this cache
  typedef struct packed {
    logic own_gets;
    logic own_getm;
    logic other_gets;
    logic other_getm;
    logic own_resp_seen;
    logic fill_data;
    logic fill_excl;
    logic req_valid;
    logic resp_valid;
  } bus_events_t;

endpackage

// File: src/coh_bus_decode.sv
`timescale 1ns/1ps

module coh_bus_decode #(
  parameter logic [coh_pkg::CACHE_ID_BITS-1:0] cache_id = '0
) (
  input  coh_pkg::req_msg_t    req_bus_msg,
  input  coh_pkg::resp_msg_t   resp_bus_msg,
  output coh_pkg::bus_events_t events
);

  import coh_pkg::*;

  logic req_is_own;
  logic req_is_gets;
  logic req_is_getm;
  logic resp_is_own;
  logic resp_to_us;

  // Source and destination compared against our ID in one place only
  assign req_is_own  = (req_bus_msg.source == cache_id);
  assign req_is_gets = req_bus_msg.valid && (req_bus_msg.op == GETS);
  assign req_is_getm = req_bus_msg.valid && (req_bus_msg.op == GETM);

  assign resp_is_own = resp_bus_msg.valid && (resp_bus_msg.source == cache_id);
  assign resp_to_us  = resp_bus_msg.valid && (resp_bus_msg.destination == cache_id);

  always_comb begin
    events = '0;

    events.req_valid  = req_bus_msg.valid;
    events.resp_valid = resp_bus_msg.valid;

    // Request bus
    events.own_gets   = req_is_gets && req_is_own;
    events.own_getm   = req_is_getm && req_is_own;
    events.other_gets = req_is_gets && !req_is_own;
    events.other_getm = req_is_getm && !req_is_own;

    // Response bus
    events.own_resp_seen = resp_is_own;
    events.fill_data     = resp_to_us && (resp_bus_msg.kind == DATA);
    events.fill_excl     = resp_to_us && (resp_bus_msg.kind == EXCLUSIVE);
  end

endmodule

// File: src/coh_line_state.sv
`timescale 1ns/1ps

module coh_line_state (
  input  logic                           clk,
  input  logic                           rst,
  input  coh_pkg::cpu_req_t              cpu,
  input  coh_pkg::way_vec_t              hit_way,
  input  coh_pkg::way_vec_t              victim_way,
  input  coh_pkg::way_vec_t              snoop_hit_way,
  input  coh_pkg::bus_events_t           events,
  input  logic [coh_pkg::INDEX_BITS-1:0] req_index,
  input  logic [coh_pkg::INDEX_BITS-1:0] resp_index,
  input  logic [coh_pkg::WAY_BITS-1:0]   resp_bus_way,
  input  logic [coh_pkg::LINE_BITS-1:0]  resp_data,
  output logic                           cpu_resp,
  output logic [coh_pkg::LINE_BITS-1:0]  cpu_rdata,
  output logic                           busy,
  output logic                           issue_valid,
  output coh_pkg::bus_op_e               issue_op,
  output logic [coh_pkg::ADDR_BITS-1:0]  issue_addr,
  output logic                           supply_valid,
  output logic                           supply_to_mem,
  output logic [coh_pkg::WAY_BITS-1:0]   supply_way
);

  import coh_pkg::*;

  coh_state_e state_q [WAYS][SETS];
  coh_state_e state_d [WAYS][SETS];

  logic                  busy_q;
  logic                  busy_d;
  logic                  hit_resp;
  logic                  fill_resp;
  logic                  cpu_access;
  logic [INDEX_BITS-1:0] cpu_index;

  assign cpu_access = cpu.read | cpu.write;
  assign cpu_index  = cpu.addr[INDEX_BITS-1:0];

  // Request bus first, then response bus, then the CPU
  always_comb begin
    state_d       = state_q;
    busy_d        = busy_q;
    hit_resp      = 1'b0;
    fill_resp     = 1'b0;
    cpu_rdata     = '0;
    issue_valid   = 1'b0;
    issue_op      = NONE;
    issue_addr    = '0;
    supply_valid  = 1'b0;
    supply_to_mem = 1'b0;
    supply_way    = '0;

    for (int i = 0; i < WAYS; i++) begin
      if (events.req_valid) begin
        // Only one miss is outstanding, so the transient state marks the way
        case (state_q[i][req_index])
          CISAD: begin
            if (events.own_gets) begin
              state_d[i][req_index] = CISD;
              busy_d = 1'b1;
            end
          end
          CIMAD: begin
            if (events.own_getm) begin
              state_d[i][req_index] = CIMD;
              busy_d = 1'b1;
            end
          end
          CS: begin
            if (events.other_getm && snoop_hit_way[i]) begin
              state_d[i][req_index] = CI;
            end
          end
          CSMAD: begin
            if (events.own_getm) begin
              state_d[i][req_index] = CSMD;
              busy_d = 1'b1;
            end else if (events.other_getm && snoop_hit_way[i]) begin
              // Lost the race, our GetM now needs the data too
              state_d[i][req_index] = CIMAD;
            end
          end
          CE, CM: begin
            if (snoop_hit_way[i] && (events.other_gets || events.other_getm)) begin
              state_d[i][req_index] = events.other_gets ? CSRD : CIRD;
              supply_valid  = 1'b1;
              supply_to_mem = events.other_gets;
              supply_way    = WAY_BITS'(i);
            end
          end
          default: begin
          end
        endcase
      end else if (events.resp_valid) begin
        case (state_q[i][resp_index])
          CISD: begin
            if (events.fill_data || events.fill_excl) begin
              state_d[i][resp_index] = events.fill_excl ? CE : CS;
              fill_resp = 1'b1;
              busy_d = 1'b0;
            end
          end
          CIMD, CSMD: begin
            if (events.fill_data || events.fill_excl) begin
              state_d[i][resp_index] = CM;
              fill_resp = 1'b1;
              busy_d = 1'b0;
            end
          end
          CSRD, CIRD: begin
            // Our own supply went out on the bus
            if (events.own_resp_seen && (resp_bus_way == WAY_BITS'(i))) begin
              state_d[i][resp_index] = (state_q[i][resp_index] == CSRD) ? CS : CI;
            end
          end
          default: begin
          end
        endcase
      end else if (cpu_access) begin
        case (state_q[i][cpu_index])
          CI: begin
            if (victim_way[i]) begin
              state_d[i][cpu_index] = cpu.read ? CISAD : CIMAD;
              issue_valid = 1'b1;
              issue_op    = cpu.read ? GETS : GETM;
              issue_addr  = cpu.addr;
            end
          end
          CS: begin
            if (hit_way[i] && cpu.read) begin
              hit_resp = 1'b1;
            end else if (hit_way[i] && cpu.write) begin
              // Upgrade
              state_d[i][cpu_index] = CSMAD;
              issue_valid = 1'b1;
              issue_op    = GETM;
              issue_addr  = cpu.addr;
            end
          end
          CSMAD, CSMD: begin
            if (hit_way[i] && cpu.read) begin
              hit_resp = 1'b1;
            end
          end
          CE: begin
            if (hit_way[i]) begin
              // Silent E to M on a store
              if (cpu.write && !cpu.read) begin
                state_d[i][cpu_index] = CM;
              end
              hit_resp = 1'b1;
            end
          end
          CM: begin
            if (hit_way[i]) begin
              hit_resp = 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end

    if (fill_resp) begin
      cpu_rdata = resp_data;
    end
  end

  assign cpu_resp = hit_resp | fill_resp;
  assign busy     = busy_d | busy_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int w = 0; w < WAYS; w++) begin
        for (int s = 0; s < SETS; s++) begin
          state_q[w][s] <= CI;
        end
      end
      busy_q <= 1'b0;
    end else begin
      state_q <= state_d;
      busy_q  <= busy_d;
    end
  end

endmodule

// File: src/coh_req_issuer.sv
`timescale 1ns/1ps

module coh_req_issuer #(
  parameter logic [coh_pkg::CACHE_ID_BITS-1:0] cache_id = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          issue_valid,
  input  coh_pkg::bus_op_e              issue_op,
  input  logic [coh_pkg::ADDR_BITS-1:0] issue_addr,
  input  coh_pkg::bus_events_t          events,
  output logic                          req_bus_req,
  output coh_pkg::req_msg_t             req_bus_tx
);

  import coh_pkg::*;

  logic own_seen;

  // Seeing our own message on the bus is the grant
  assign own_seen = events.own_gets | events.own_getm;

  always_ff @(posedge clk) begin
    if (rst) begin
      req_bus_req       <= 1'b0;
      req_bus_tx.valid  <= 1'b0;
      req_bus_tx.source <= cache_id;
      req_bus_tx.addr   <= '0;
      req_bus_tx.op     <= NONE;
    end else if (req_bus_req) begin
      // Hold until granted, arbiter back-pressure just stretches this
      if (own_seen) begin
        req_bus_req       <= 1'b0;
        req_bus_tx.valid  <= 1'b0;
        req_bus_tx.source <= cache_id;
        req_bus_tx.addr   <= '0;
        req_bus_tx.op     <= NONE;
      end
    end else if (issue_valid) begin
      req_bus_req       <= 1'b1;
      req_bus_tx.valid  <= 1'b1;
      req_bus_tx.source <= cache_id;
      req_bus_tx.addr   <= issue_addr;
      req_bus_tx.op     <= issue_op;
    end
  end

endmodule

// File: src/coh_snoop_responder.sv
`timescale 1ns/1ps

module coh_snoop_responder #(
  parameter logic [coh_pkg::CACHE_ID_BITS-1:0] cache_id = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          supply_valid,
  input  logic [coh_pkg::WAY_BITS-1:0]  supply_way,
  input  logic                          supply_to_mem,
  input  logic [coh_pkg::LINE_BITS-1:0] snoop_data,
  input  coh_pkg::req_msg_t             req_bus_msg,
  input  coh_pkg::bus_events_t          events,
  output logic                          resp_bus_req,
  output coh_pkg::resp_msg_t            resp_bus_tx
);

  import coh_pkg::*;

  // Control bits are reset, the line payload is not
  always_ff @(posedge clk) begin
    if (rst) begin
      resp_bus_req      <= 1'b0;
      resp_bus_tx.valid <= 1'b0;
    end else if (resp_bus_req) begin
      if (events.own_resp_seen) begin
        resp_bus_req      <= 1'b0;
        resp_bus_tx.valid <= 1'b0;
      end
    end else if (supply_valid) begin
      resp_bus_req      <= 1'b1;
      resp_bus_tx.valid <= 1'b1;
    end
  end

  // Message body captured with the snooped request
  always_ff @(posedge clk) begin
    if (supply_valid && !resp_bus_req) begin
      resp_bus_tx.source      <= cache_id;
      resp_bus_tx.way         <= supply_way;
      resp_bus_tx.destination <= req_bus_msg.source;
      // GetS also updates memory, GetM hands ownership over
      resp_bus_tx.memory_flag <= supply_to_mem;
      resp_bus_tx.addr        <= req_bus_msg.addr;
      resp_bus_tx.data        <= snoop_data;
      resp_bus_tx.kind        <= DATA;
    end
  end

endmodule

// File: src/dcache_coherence.sv
`timescale 1ns/1ps

module dcache_coherence #(
  parameter logic [coh_pkg::CACHE_ID_BITS-1:0] cache_id = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  coh_pkg::cpu_req_t             cpu,
  input  coh_pkg::way_vec_t             hit_way,
  input  coh_pkg::way_vec_t             victim_way,
  input  coh_pkg::way_vec_t             snoop_hit_way,
  input  logic [coh_pkg::LINE_BITS-1:0] snoop_data,
  input  coh_pkg::req_msg_t             req_bus_msg,
  input  coh_pkg::resp_msg_t            resp_bus_msg,
  output logic                          cpu_resp,
  output logic [coh_pkg::LINE_BITS-1:0] cpu_rdata,
  output logic                          req_bus_req,
  output coh_pkg::req_msg_t             req_bus_tx,
  output logic                          resp_bus_req,
  output coh_pkg::resp_msg_t            resp_bus_tx,
  output logic                          busy
);

  import coh_pkg::*;

  bus_events_t           bus_events;
  logic [INDEX_BITS-1:0] req_index;
  logic [INDEX_BITS-1:0] resp_index;
  logic                  issue_valid;
  bus_op_e               issue_op;
  logic [ADDR_BITS-1:0]  issue_addr;
  logic                  supply_valid;
  logic                  supply_to_mem;
  logic [WAY_BITS-1:0]   supply_way;

  // Set index sits in the low address bits
  assign req_index  = req_bus_msg.addr[INDEX_BITS-1:0];
  assign resp_index = resp_bus_msg.addr[INDEX_BITS-1:0];

  coh_bus_decode #(.cache_id(cache_id)) u_decode (
    .req_bus_msg  (req_bus_msg),
    .resp_bus_msg (resp_bus_msg),
    .events       (bus_events)
  );

  coh_line_state u_line_state (
    .clk           (clk),
    .rst           (rst),
    .cpu           (cpu),
    .hit_way       (hit_way),
    .victim_way    (victim_way),
    .snoop_hit_way (snoop_hit_way),
    .events        (bus_events),
    .req_index     (req_index),
    .resp_index    (resp_index),
    .resp_bus_way  (resp_bus_msg.way),
    .resp_data     (resp_bus_msg.data),
    .cpu_resp      (cpu_resp),
    .cpu_rdata     (cpu_rdata),
    .busy          (busy),
    .issue_valid   (issue_valid),
    .issue_op      (issue_op),
    .issue_addr    (issue_addr),
    .supply_valid  (supply_valid),
    .supply_to_mem (supply_to_mem),
    .supply_way    (supply_way)
  );

  coh_req_issuer #(.cache_id(cache_id)) u_req_issuer (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_addr  (issue_addr),
    .events      (bus_events),
    .req_bus_req (req_bus_req),
    .req_bus_tx  (req_bus_tx)
  );

  coh_snoop_responder #(.cache_id(cache_id)) u_snoop_responder (
    .clk           (clk),
    .rst           (rst),
    .supply_valid  (supply_valid),
    .supply_way    (supply_way),
    .supply_to_mem (supply_to_mem),
    .snoop_data    (snoop_data),
    .req_bus_msg   (req_bus_msg),
    .events        (bus_events),
    .resp_bus_req  (resp_bus_req),
    .resp_bus_tx   (resp_bus_tx)
  );

endmodule

// File: sim/coh_tb_tasks.svh
task automatic check_eq(input string what, input logic [LINE_BITS-1:0] exp,
                        input logic [LINE_BITS-1:0] act);
  assert (act === exp) else begin
    $display("** Error: %s: %s expected 0x%0h, actual 0x%0h", test_name, what, exp, act);
    $display("Verification failed");
    $fatal(1, "Stopped at first mismatch");
  end
endtask

function automatic logic [LINE_BITS-1:0] rand_line();
  logic [LINE_BITS-1:0] line;
  for (int i = 0; i < LINE_BITS / 32; i++) begin
    line[i*32 +: 32] = $urandom();
  end
  return line;
endfunction

// Any cache ID except the DUT's
function automatic logic [CACHE_ID_BITS-1:0] other_id();
  int unsigned id;
  id = $urandom_range(NUM_CACHE - 2, 0);
  if (id >= TB_CACHE_ID) begin
    id++;
  end
  return CACHE_ID_BITS'(id);
endfunction

function automatic logic [ADDR_BITS-1:0] set_addr(input int set);
  logic [ADDR_BITS-1:0] addr;
  addr = $urandom();
  addr[INDEX_BITS-1:0] = INDEX_BITS'(set);
  return addr;
endfunction

// Bus model driving one message for one cycle from a falling edge
task automatic echo_req(input req_msg_t msg);
  req_bus_msg = msg;
  #1;
  obs_busy = busy;
  @(negedge clk);
  req_bus_msg = '0;
endtask

task automatic echo_resp(input resp_msg_t msg);
  resp_bus_msg = msg;
  #1;
  obs_cpu_resp  = cpu_resp;
  obs_cpu_rdata = cpu_rdata;
  @(negedge clk);
  resp_bus_msg = '0;
endtask

// One CPU access for one cycle
task automatic cpu_cycle(input logic rd, input logic wr, input logic [ADDR_BITS-1:0] addr,
                         input way_vec_t hit, input way_vec_t victim);
  cpu.read   = rd;
  cpu.write  = wr;
  cpu.addr   = addr;
  hit_way    = hit;
  victim_way = victim;
  #1;
  obs_cpu_resp = cpu_resp;
  @(negedge clk);
  cpu        = '0;
  hit_way    = '0;
  victim_way = '0;
endtask

task automatic send_fill(input logic [ADDR_BITS-1:0] addr, input resp_kind_e kind,
                         input logic [LINE_BITS-1:0] data);
  resp_msg_t msg;
  msg             = '0;
  msg.valid       = 1'b1;
  msg.source      = other_id();
  msg.destination = TB_CACHE_ID;
  msg.addr        = addr;
  msg.data        = data;
  msg.kind        = kind;
  echo_resp(msg);
endtask

// Miss into a CI victim way, own request, then the fill
task automatic bring_in(input logic [ADDR_BITS-1:0] addr, input int way, input logic store,
                        input resp_kind_e kind, output logic [LINE_BITS-1:0] data);
  data = rand_line();
  cpu_cycle(!store, store, addr, '0, way_vec_t'(1 << way));
  check_eq("cpu_resp on miss", 0, obs_cpu_resp);
  check_eq("req_bus_req after miss", 1, req_bus_req);
  check_eq("req valid", 1, req_bus_tx.valid);
  check_eq("req op", store ? GETM : GETS, req_bus_tx.op);
  check_eq("req addr", addr, req_bus_tx.addr);
  check_eq("req source", TB_CACHE_ID, req_bus_tx.source);
  echo_req(req_bus_tx);
  check_eq("busy on own request", 1, obs_busy);
  check_eq("req_bus_req after own request", 0, req_bus_req);
  check_eq("busy waiting for fill", 1, busy);
  send_fill(addr, kind, data);
  check_eq("cpu_resp on fill", 1, obs_cpu_resp);
  check_eq("cpu_rdata on fill", data, obs_cpu_rdata);
  check_eq("busy after fill", 0, busy);
endtask

task automatic snoop_request(input bus_op_e op, input logic [ADDR_BITS-1:0] addr,
                             input int way, input logic [CACHE_ID_BITS-1:0] requester,
                             input logic [LINE_BITS-1:0] data);
  req_msg_t msg;
  msg           = '0;
  msg.valid     = 1'b1;
  msg.source    = requester;
  msg.addr      = addr;
  msg.op        = op;
  snoop_hit_way = way_vec_t'(1 << way);
  snoop_data    = data;
  echo_req(msg);
  snoop_hit_way = '0;
endtask

task automatic check_supply(input int way, input logic [CACHE_ID_BITS-1:0] requester,
                            input logic mem_flag, input logic [ADDR_BITS-1:0] addr,
                            input logic [LINE_BITS-1:0] data);
  check_eq("resp_bus_req on supply", 1, resp_bus_req);
  check_eq("resp valid", 1, resp_bus_tx.valid);
  check_eq("resp source", TB_CACHE_ID, resp_bus_tx.source);
  check_eq("resp kind", DATA, resp_bus_tx.kind);
  check_eq("resp way", way, resp_bus_tx.way);
  check_eq("resp destination", requester, resp_bus_tx.destination);
  check_eq("resp memory_flag", mem_flag, resp_bus_tx.memory_flag);
  check_eq("resp addr", addr, resp_bus_tx.addr);
  check_eq("resp data", data, resp_bus_tx.data);
  echo_resp(resp_bus_tx);
  check_eq("resp_bus_req after own response", 0, resp_bus_req);
endtask

task automatic test_reset();
  test_name = "reset";
  check_eq("req_bus_req", 0, req_bus_req);
  check_eq("resp_bus_req", 0, resp_bus_req);
  check_eq("busy", 0, busy);
  check_eq("cpu_resp", 0, cpu_resp);
  cpu_cycle(1'b1, 1'b0, set_addr(0), '1, '0);
  check_eq("cpu_resp on CI line", 0, obs_cpu_resp);
  check_eq("req_bus_req without victim", 0, req_bus_req);
endtask

task automatic test_load_shared();
  logic [ADDR_BITS-1:0] addr;
  logic [LINE_BITS-1:0] data;
  int                   way;
  test_name = "load_shared_fill";
  addr = set_addr(2);
  way  = $urandom_range(WAYS - 1, 0);
  bring_in(addr, way, 1'b0, DATA, data);
  cpu_cycle(1'b1, 1'b0, addr, way_vec_t'(1 << way), '0);
  check_eq("cpu_resp on load hit", 1, obs_cpu_resp);
  // Store to S goes out as an upgrade
  cpu_cycle(1'b0, 1'b1, addr, way_vec_t'(1 << way), '0);
  check_eq("cpu_resp on store to S", 0, obs_cpu_resp);
  check_eq("req_bus_req for upgrade", 1, req_bus_req);
  check_eq("upgrade op", GETM, req_bus_tx.op);
  check_eq("upgrade addr", addr, req_bus_tx.addr);
  echo_req(req_bus_tx);
  check_eq("busy during upgrade", 1, busy);
  send_fill(addr, DATA, data);
  check_eq("cpu_resp on upgrade fill", 1, obs_cpu_resp);
  check_eq("busy after upgrade", 0, busy);
endtask

task automatic test_excl_store();
  logic [ADDR_BITS-1:0] addr;
  logic [LINE_BITS-1:0] data;
  int                   way;
  test_name = "exclusive_silent_store";
  addr = set_addr(3);
  way  = $urandom_range(WAYS - 1, 0);
  bring_in(addr, way, 1'b0, EXCLUSIVE, data);
  cpu_cycle(1'b0, 1'b1, addr, way_vec_t'(1 << way), '0);
  check_eq("cpu_resp on store to E", 1, obs_cpu_resp);
  check_eq("req_bus_req after silent store", 0, req_bus_req);
endtask

task automatic test_snoop_gets_m();
  logic [ADDR_BITS-1:0]     addr;
  logic [LINE_BITS-1:0]     data;
  logic [LINE_BITS-1:0]     sdata;
  logic [CACHE_ID_BITS-1:0] requester;
  int                       way;
  test_name = "snoop_gets_on_m";
  addr      = set_addr(4);
  way       = $urandom_range(WAYS - 1, 0);
  requester = other_id();
  sdata     = rand_line();
  bring_in(addr, way, 1'b1, DATA, data);
  snoop_request(GETS, addr, way, requester, sdata);
  check_supply(way, requester, 1'b1, addr, sdata);
  // Loads still hit the line in S
  cpu_cycle(1'b1, 1'b0, addr, way_vec_t'(1 << way), '0);
  check_eq("cpu_resp on load after GetS", 1, obs_cpu_resp);
endtask

task automatic test_snoop_getm();
  logic [ADDR_BITS-1:0]     addr;
  logic [LINE_BITS-1:0]     data;
  logic [LINE_BITS-1:0]     sdata;
  logic [CACHE_ID_BITS-1:0] requester;
  int                       way;
  test_name = "snoop_getm_on_s";
  addr      = set_addr(5);
  way       = $urandom_range(WAYS - 1, 0);
  requester = other_id();
  bring_in(addr, way, 1'b0, DATA, data);
  snoop_request(GETM, addr, way, requester, rand_line());
  check_eq("resp_bus_req on S line", 0, resp_bus_req);
  cpu_cycle(1'b1, 1'b0, addr, way_vec_t'(1 << way), '0);
  check_eq("cpu_resp after invalidation", 0, obs_cpu_resp);

  test_name = "snoop_getm_on_m";
  addr      = set_addr(6);
  way       = $urandom_range(WAYS - 1, 0);
  requester = other_id();
  sdata     = rand_line();
  bring_in(addr, way, 1'b1, DATA, data);
  snoop_request(GETM, addr, way, requester, sdata);
  check_supply(way, requester, 1'b0, addr, sdata);
  cpu_cycle(1'b1, 1'b0, addr, way_vec_t'(1 << way), '0);
  check_eq("cpu_resp after ownership moved", 0, obs_cpu_resp);
endtask

// File: sim/tb_dcache_coherence.sv
`timescale 1ns/1ps

module tb_dcache_coherence;

  import coh_pkg::*;

  localparam logic [CACHE_ID_BITS-1:0] TB_CACHE_ID = 2'd1;
  localparam int unsigned SEED = 32'h0d9b_0c49;
  localparam int NUM_TESTS = 5;
  localparam int CYCLES_PER_TEST = 200;
  localparam int WATCHDOG_CYCLES = NUM_TESTS * CYCLES_PER_TEST;

  logic                 clk;
  logic                 rst;
  cpu_req_t             cpu;
  way_vec_t             hit_way;
  way_vec_t             victim_way;
  way_vec_t             snoop_hit_way;
  logic [LINE_BITS-1:0] snoop_data;
  req_msg_t             req_bus_msg;
  resp_msg_t            resp_bus_msg;

  logic                 cpu_resp;
  logic [LINE_BITS-1:0] cpu_rdata;
  logic                 req_bus_req;
  req_msg_t             req_bus_tx;
  logic                 resp_bus_req;
  resp_msg_t            resp_bus_tx;
  logic                 busy;

  // Values sampled in the middle of a bus or CPU cycle
  logic                 obs_cpu_resp;
  logic [LINE_BITS-1:0] obs_cpu_rdata;
  logic                 obs_busy;

  string                test_name;
  int unsigned          seed_ret;

  dcache_coherence #(.cache_id(TB_CACHE_ID)) DUT (
    .clk           (clk),
    .rst           (rst),
    .cpu           (cpu),
    .hit_way       (hit_way),
    .victim_way    (victim_way),
    .snoop_hit_way (snoop_hit_way),
    .snoop_data    (snoop_data),
    .req_bus_msg   (req_bus_msg),
    .resp_bus_msg  (resp_bus_msg),
    .cpu_resp      (cpu_resp),
    .cpu_rdata     (cpu_rdata),
    .req_bus_req   (req_bus_req),
    .req_bus_tx    (req_bus_tx),
    .resp_bus_req  (resp_bus_req),
    .resp_bus_tx   (resp_bus_tx),
    .busy          (busy)
  );

  always #5 clk = ~clk;

  `include "coh_tb_tasks.svh"

  // Watchdog sized from the number of tests
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $fatal(1, "Watchdog expired");
  end

  initial begin
    clk           = 1'b0;
    rst           = 1'b1;
    cpu           = '0;
    hit_way       = '0;
    victim_way    = '0;
    snoop_hit_way = '0;
    snoop_data    = '0;
    req_bus_msg   = '0;
    resp_bus_msg  = '0;
    obs_cpu_resp  = 1'b0;
    obs_cpu_rdata = '0;
    obs_busy      = 1'b0;
    test_name     = "init";
    seed_ret      = $urandom(SEED);

    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_reset();
    test_load_shared();
    test_excl_store();
    test_snoop_gets_m();
    test_snoop_getm();

    $display("Verification passed");
    $finish;
  end

endmodule

// File: filelist.f
+incdir+sim
src/coh_pkg.sv
src/coh_bus_decode.sv
src/coh_line_state.sv
src/coh_req_issuer.sv
src/coh_snoop_responder.sv
src/dcache_coherence.sv
sim/tb_dcache_coherence.sv

// File: Bender.yml
package:
  name: dcache_coherence

sources:
  - files:
      - src/coh_pkg.sv
      - src/coh_bus_decode.sv
      - src/coh_line_state.sv
      - src/coh_req_issuer.sv
      - src/coh_snoop_responder.sv
      - src/dcache_coherence.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_dcache_coherence.sv
